// ==== include/video_settings.svh ====
/*
 * Video subsystem settings
 * Raster geometry and memory sizes shared by the video blocks
 */
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// Raster, kept small for short simulations
`define VID_H_TOTAL      64
`define VID_H_ACTIVE     48
`define VID_H_SYNC_START 52
`define VID_H_SYNC_LEN   4
`define VID_V_TOTAL      40
`define VID_V_ACTIVE     32
`define VID_V_SYNC_START 34
`define VID_V_SYNC_LEN   2

// Memories
`define VID_TILE_COLS    8
`define VID_VRAM_DEPTH   32
`define VID_OBJ_COUNT    4
`define VID_PAL_DEPTH    32

`endif

// ==== logic/video_timing_pkg.sv ====
/*
 * Video timing types
 * Raster position with blanking and sync, broadcast by the timer
 */
package video_timing_pkg;

    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        // High while visible
        logic       lhbl;
        logic       lvbl;
        logic       hs;
        logic       vs;
    } raster_t;

endpackage

// ==== logic/video_gfx_pkg.sv ====
/*
 * Video graphics types
 * Colours, palette indexes, object attributes and layer pixels
 */
package video_gfx_pkg;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // 0-15 tile colours, 16-31 object colours
    typedef logic [4:0] pal_idx_t;

    typedef struct packed {
        logic [7:0] y;
        logic [7:0] x;
        logic [3:0] color;
    } obj_attr_t;

    // Zero means transparent
    typedef logic [3:0] layer_pxl_t;

endpackage

// ==== logic/cpu_ram.sv ====
/*
 * Simple dual-port RAM
 * One write port, one read port, one clock of read latency
 * Payload type set by parameter
 */
module cpu_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 32
) (
    input                             clk,
    input  logic                      we,
    input  logic [$clog2(DEPTH)-1:0]  waddr,
    input  entry_t                    wdata,
    input  logic [$clog2(DEPTH)-1:0]  raddr,
    output entry_t                    rdata
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

    a_waddr_range: assert property (@(posedge clk) we |-> waddr < DEPTH);

endmodule

// ==== logic/video_timer.sv ====
/*
 * Raster timer
 * Pixel and line counters advancing on pxl_cen, with blanking and sync
 * registered together with the counts
 */
`include "video_settings.svh"

module video_timer (
    input                                clk,
    input                                rst_n,
    input                                pxl_cen,
    output video_timing_pkg::raster_t    raster
);

    logic [8:0] h_next;
    logic [8:0] v_next;

    always_comb begin
        h_next = raster.hdump + 9'd1;
        v_next = raster.vdump;
        if (raster.hdump == 9'(`VID_H_TOTAL - 1)) begin
            h_next = '0;
            if (raster.vdump == 9'(`VID_V_TOTAL - 1)) begin
                v_next = '0;
            end else begin
                v_next = raster.vdump + 9'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            raster <= '0;
        end else if (pxl_cen) begin
            raster.hdump <= h_next;
            raster.vdump <= v_next;
            raster.lhbl  <= h_next < `VID_H_ACTIVE;
            raster.lvbl  <= v_next < `VID_V_ACTIVE;
            raster.hs    <= h_next >= `VID_H_SYNC_START &&
                            h_next < `VID_H_SYNC_START + `VID_H_SYNC_LEN;
            // VS covers whole lines
            raster.vs    <= v_next >= `VID_V_SYNC_START &&
                            v_next < `VID_V_SYNC_START + `VID_V_SYNC_LEN;
        end
    end

    a_hdump_range: assert property (@(posedge clk) disable iff (!rst_n)
        raster.hdump < `VID_H_TOTAL);

endmodule

// ==== logic/tile_layer.sv ====
/*
 * Tile layer
 * Looks up the next tile code in VRAM, fetches its graphics row from ROM
 * and shifts the row out one 4-bit pixel per pxl_cen
 */
`include "video_settings.svh"

module tile_layer (
    input                                clk,
    input                                rst_n,
    input                                pxl_cen,
    input  video_timing_pkg::raster_t    raster,
    input  logic [7:0]                   cpu_addr,
    input  logic [7:0]                   cpu_dout,
    input  logic                         vram_we,
    output logic                         rom_cs,
    output logic [10:0]                  rom_addr,
    input  logic [31:0]                  rom_data,
    input  logic                         rom_ok,
    output video_gfx_pkg::layer_pxl_t    pxl
);

    localparam int vram_aw = $clog2(`VID_VRAM_DEPTH);
    localparam int col_w   = $clog2(`VID_TILE_COLS);

    typedef enum logic [1:0] {st_idle, st_rd, st_req, st_rom} fetch_st_t;

    fetch_st_t          st;
    logic               tile_start;
    logic               last_tile;
    logic [8:0]         tline;
    logic [col_w-1:0]   tcol;
    logic [vram_aw-1:0] vram_raddr;
    logic [7:0]         vram_code;
    logic [31:0]        row_buf;
    logic [31:0]        shift;

    assign tile_start = pxl_cen && raster.hdump[2:0] == 3'd0;

    // Next tile, wrapping to column 0 of the next line in the last tile
    assign last_tile = raster.hdump >= 9'(`VID_H_TOTAL - 8);
    assign tcol      = last_tile ? '0 : col_w'(raster.hdump[8:3] + 6'd1);

    always_comb begin
        tline = raster.vdump;
        if (last_tile) begin
            tline = (raster.vdump == 9'(`VID_V_TOTAL - 1)) ? '0 : raster.vdump + 9'd1;
        end
    end

    assign vram_raddr = vram_aw'(tline[8:3] * `VID_TILE_COLS + tcol);

    cpu_ram #(
        .entry_t ( logic [7:0]        ),
        .DEPTH   ( `VID_VRAM_DEPTH    )
    ) u_vram (
        .clk     ( clk                      ),
        .we      ( vram_we                  ),
        .waddr   ( cpu_addr[vram_aw-1:0]    ),
        .wdata   ( cpu_dout                 ),
        .raddr   ( vram_raddr               ),
        .rdata   ( vram_code                )
    );

    // Fetch sequence, rom_ok expected within 12 clocks of the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st     <= st_idle;
            rom_cs <= 1'b0;
        end else begin
            case (st)
                st_idle: if (tile_start) st <= st_rd;
                st_rd:   st <= st_req;
                st_req: begin
                    rom_cs <= 1'b1;
                    st     <= st_rom;
                end
                st_rom: if (rom_ok) begin
                    rom_cs <= 1'b0;
                    st     <= st_idle;
                end
                default: st <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == st_req) begin
            rom_addr <= {vram_code, tline[2:0]};
        end
        if (st == st_rom && rom_ok) begin
            row_buf <= rom_data;
        end
        if (tile_start) begin
            shift <= row_buf >> 4;
        end else if (pxl_cen) begin
            shift <= shift >> 4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= tile_start ? row_buf[3:0] : shift[3:0];
        end
    end

    a_rom_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rom_cs && !rom_ok |=> rom_cs);

endmodule

// ==== logic/obj_layer.sv ====
/*
 * Object layer
 * Up to VID_OBJ_COUNT solid 8x8 objects placed by the CPU
 * Lowest index with a non-zero colour wins
 */
`include "video_settings.svh"

module obj_layer (
    input                                clk,
    input                                rst_n,
    input                                pxl_cen,
    input  video_timing_pkg::raster_t    raster,
    input  logic [7:0]                   cpu_addr,
    input  logic [7:0]                   cpu_dout,
    input  logic                         obj_we,
    output video_gfx_pkg::layer_pxl_t    pxl
);

    localparam int sel_w = $clog2(`VID_OBJ_COUNT);

    video_gfx_pkg::obj_attr_t   objs [`VID_OBJ_COUNT];
    video_gfx_pkg::layer_pxl_t  hit_pxl;
    logic [8:0]                 dx;
    logic [8:0]                 dy;

    // Field select in the low address bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `VID_OBJ_COUNT; i++) begin
                objs[i] <= '0;
            end
        end else if (obj_we) begin
            case (cpu_addr[1:0])
                2'd0: objs[cpu_addr[sel_w+1:2]].y     <= cpu_dout;
                2'd1: objs[cpu_addr[sel_w+1:2]].x     <= cpu_dout;
                2'd2: objs[cpu_addr[sel_w+1:2]].color <= cpu_dout[3:0];
                default: ;
            endcase
        end
    end

    // Walk from the highest index down so the lowest one is left standing
    always_comb begin
        hit_pxl = '0;
        dx      = '0;
        dy      = '0;
        for (int i = `VID_OBJ_COUNT - 1; i >= 0; i--) begin
            // Wraps to a large value left of or above the object
            dx = raster.hdump - {1'b0, objs[i].x};
            dy = raster.vdump - {1'b0, objs[i].y};
            if (dx < 9'd8 && dy < 9'd8 && objs[i].color != '0) begin
                hit_pxl = objs[i].color;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= (raster.lhbl && raster.lvbl) ? hit_pxl : '0;
        end
    end

endmodule

// ==== logic/color_mixer.sv ====
/*
 * Colour mixer
 * Objects over tiles, 12-bit palette lookup and blanking
 * Blanking is delayed to stay aligned with rgb
 */
`include "video_settings.svh"

module color_mixer (
    input                                clk,
    input                                rst_n,
    input                                pxl_cen,
    input  video_timing_pkg::raster_t    raster,
    input  video_gfx_pkg::layer_pxl_t    tile_pxl,
    input  video_gfx_pkg::layer_pxl_t    obj_pxl,
    input  logic                         prog_en,
    input  video_gfx_pkg::pal_idx_t      prog_addr,
    input  video_gfx_pkg::rgb_t          prog_data,
    output video_gfx_pkg::rgb_t          rgb,
    output logic                         LHBL_dly,
    output logic                         LVBL_dly
);

    video_gfx_pkg::pal_idx_t    pal_raddr;
    video_gfx_pkg::rgb_t        pal_rdata;
    logic                       lhbl_d1;
    logic                       lvbl_d1;

    // Object colours live in the upper half
    assign pal_raddr = (obj_pxl != '0) ? {1'b1, obj_pxl} : {1'b0, tile_pxl};

    cpu_ram #(
        .entry_t ( video_gfx_pkg::rgb_t ),
        .DEPTH   ( `VID_PAL_DEPTH       )
    ) u_palette (
        .clk     ( clk       ),
        .we      ( prog_en   ),
        .waddr   ( prog_addr ),
        .wdata   ( prog_data ),
        .raddr   ( pal_raddr ),
        .rdata   ( pal_rdata )
    );

    // Palette data settles one clock after the layers, so pxl_cen is at most every other clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lhbl_d1  <= 1'b0;
            lvbl_d1  <= 1'b0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            rgb      <= '0;
        end else if (pxl_cen) begin
            lhbl_d1  <= raster.lhbl;
            lvbl_d1  <= raster.lvbl;
            LHBL_dly <= lhbl_d1;
            LVBL_dly <= lvbl_d1;
            rgb      <= (lhbl_d1 && lvbl_d1) ? pal_rdata : '0;
        end
    end

    a_blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        (!LHBL_dly || !LVBL_dly) |-> rgb == '0);

endmodule

// ==== logic/video_top.sv ====
/*
 * Video top
 * Raster timer, tile layer, object layer and colour mixer
 */
module video_top (
    input                           clk,
    input                           rst_n,
    input                           pxl_cen,
    // CPU interface
    input  logic [7:0]              cpu_addr,
    input  logic [7:0]              cpu_dout,
    input  logic                    cpu_we,
    input  logic                    vram_cs,
    input  logic                    obj_cs,
    // Palette programming
    input  logic                    prog_en,
    input  logic [4:0]              prog_addr,
    input  logic [11:0]             prog_data,
    // Tile ROM
    output logic                    rom_cs,
    output logic [10:0]             rom_addr,
    input  logic [31:0]             rom_data,
    input  logic                    rom_ok,
    output logic                    HS,
    output logic                    VS,
    output logic                    LHBL_dly,
    output logic                    LVBL_dly,
    output video_gfx_pkg::rgb_t     rgb
);

    video_timing_pkg::raster_t  raster;
    video_gfx_pkg::layer_pxl_t  tile_pxl;
    video_gfx_pkg::layer_pxl_t  obj_pxl;
    logic                       vram_we;
    logic                       obj_we;

    assign vram_we = cpu_we & vram_cs;
    assign obj_we  = cpu_we & obj_cs;
    assign HS      = raster.hs;
    assign VS      = raster.vs;

    video_timer u_timer(
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .pxl_cen    ( pxl_cen   ),
        .raster     ( raster    )
    );

    tile_layer u_tile(
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .pxl_cen    ( pxl_cen   ),
        .raster     ( raster    ),
        .cpu_addr   ( cpu_addr  ),
        .cpu_dout   ( cpu_dout  ),
        .vram_we    ( vram_we   ),
        .rom_cs     ( rom_cs    ),
        .rom_addr   ( rom_addr  ),
        .rom_data   ( rom_data  ),
        .rom_ok     ( rom_ok    ),
        .pxl        ( tile_pxl  )
    );

    obj_layer u_obj(
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .pxl_cen    ( pxl_cen   ),
        .raster     ( raster    ),
        .cpu_addr   ( cpu_addr  ),
        .cpu_dout   ( cpu_dout  ),
        .obj_we     ( obj_we    ),
        .pxl        ( obj_pxl   )
    );

    color_mixer u_colmix(
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .pxl_cen    ( pxl_cen   ),
        .raster     ( raster    ),
        .tile_pxl   ( tile_pxl  ),
        .obj_pxl    ( obj_pxl   ),
        .prog_en    ( prog_en   ),
        .prog_addr  ( prog_addr ),
        .prog_data  ( prog_data ),
        .rgb        ( rgb       ),
        .LHBL_dly   ( LHBL_dly  ),
        .LVBL_dly   ( LVBL_dly  )
    );

endmodule

// ==== dv/video_tb.sv ====
/*
 * Video subsystem testbench
 * Loads palette, VRAM and objects, answers the tile ROM with random latency
 * and checks raster, pixels, blanking and the ROM hold with assertions
 */
`include "video_settings.svh"

module video_tb;

    localparam int frame_limit = 2 * `VID_H_TOTAL * `VID_V_TOTAL + 200;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       pxl_cen;
    logic [7:0]                 cpu_addr;
    logic [7:0]                 cpu_dout;
    logic                       cpu_we;
    logic                       vram_cs;
    logic                       obj_cs;
    logic                       prog_en;
    logic [4:0]                 prog_addr;
    logic [11:0]                prog_data;
    logic                       rom_cs;
    logic [10:0]                rom_addr;
    logic [31:0]                rom_data;
    logic                       rom_ok;
    logic                       HS;
    logic                       VS;
    logic                       LHBL_dly;
    logic                       LVBL_dly;
    video_gfx_pkg::rgb_t        rgb;

    integer                     seed = 32'hb093_2d93;

    // Shadow copies of what was written into the DUT
    logic [7:0]                 vram_img [`VID_VRAM_DEPTH];
    video_gfx_pkg::rgb_t        pal_img [`VID_PAL_DEPTH];
    video_gfx_pkg::obj_attr_t   obj_img [`VID_OBJ_COUNT];

    // Raster tracking on each pixel strobe
    logic                       prev_hs;
    logic                       prev_vs;
    logic                       prev_lhbl;
    logic                       armed;
    logic                       hs_rise;
    logic                       vs_rise;
    logic                       lhbl_fall;
    int                         hcnt;
    int                         hact;
    int                         lcnt;
    int                         vact;
    int                         px;
    int                         py;
    int                         vs_count;

    logic [7:0]                 exp_code;
    logic [31:0]                exp_row;
    video_gfx_pkg::pal_idx_t    exp_idx;
    logic                       obj_found;
    video_gfx_pkg::rgb_t        exp_rgb;

    int                         hline_errs = 0;
    int                         hact_errs = 0;
    int                         vline_errs = 0;
    int                         vact_errs = 0;
    int                         pixel_errs = 0;
    int                         blank_errs = 0;
    int                         rom_errs = 0;
    int                         timeouts = 0;
    int                         total;

    video_top u_dut (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .pxl_cen    ( pxl_cen   ),
        .cpu_addr   ( cpu_addr  ),
        .cpu_dout   ( cpu_dout  ),
        .cpu_we     ( cpu_we    ),
        .vram_cs    ( vram_cs   ),
        .obj_cs     ( obj_cs    ),
        .prog_en    ( prog_en   ),
        .prog_addr  ( prog_addr ),
        .prog_data  ( prog_data ),
        .rom_cs     ( rom_cs    ),
        .rom_addr   ( rom_addr  ),
        .rom_data   ( rom_data  ),
        .rom_ok     ( rom_ok    ),
        .HS         ( HS        ),
        .VS         ( VS        ),
        .LHBL_dly   ( LHBL_dly  ),
        .LVBL_dly   ( LVBL_dly  ),
        .rgb        ( rgb       )
    );

    always #5 clk = ~clk;

    // Pixel strobe on every other clock
    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            pxl_cen = ~pxl_cen;
        end
    end

    // Tile graphics content as a fixed scramble of the ROM address
    function automatic logic [31:0] rom_hash(input logic [10:0] addr);
        logic [31:0] h;
        h = {21'd0, addr} * 32'h9e37_79b1;
        h = h ^ (h >> 13) ^ 32'h5a5a_c3c3;
        return h;
    endfunction

    // Tile ROM with 1 to 4 clocks of latency
    initial begin
        int delay;
        rom_ok   = 1'b0;
        rom_data = '0;
        forever begin
            @(posedge clk);
            if (rom_cs === 1'b1) begin
                delay = 1 + int'($unsigned($random(seed)) % 4);
                repeat (delay - 1) @(posedge clk);
                #1;
                rom_data = rom_hash(rom_addr);
                rom_ok   = 1'b1;
                @(posedge clk);
                #1;
                rom_ok   = 1'b0;
            end
        end
    end

    assign hs_rise   = HS && !prev_hs;
    assign vs_rise   = VS && !prev_vs;
    assign lhbl_fall = !LHBL_dly && prev_lhbl;

    always @(posedge clk) begin
        if (!rst_n) begin
            prev_hs   <= 1'b0;
            prev_vs   <= 1'b0;
            prev_lhbl <= 1'b0;
            armed     <= 1'b0;
            hcnt      <= 0;
            hact      <= 0;
            lcnt      <= 0;
            vact      <= 0;
            px        <= 0;
            py        <= 0;
            vs_count  <= 0;
        end else if (pxl_cen) begin
            prev_hs   <= HS;
            prev_vs   <= VS;
            prev_lhbl <= LHBL_dly;
            hcnt      <= hs_rise ? 1 : hcnt + 1;
            hact      <= LHBL_dly ? hact + 1 : 0;
            px        <= (LHBL_dly && LVBL_dly) ? px + 1 : 0;
            if (vs_rise) begin
                armed    <= 1'b1;
                vs_count <= vs_count + 1;
                lcnt     <= 0;
                vact     <= 0;
                py       <= 0;
            end else begin
                if (hs_rise) begin
                    lcnt <= lcnt + 1;
                end
                if (lhbl_fall && LVBL_dly) begin
                    vact <= vact + 1;
                    py   <= py + 1;
                end
            end
        end
    end

    // Reference colour of screen pixel (px, py)
    always_comb begin
        exp_code  = vram_img[5'((py / 8) * `VID_TILE_COLS + px / 8)];
        exp_row   = rom_hash({exp_code, 3'(py % 8)});
        exp_idx   = {1'b0, 4'(exp_row >> (4 * (px % 8)))};
        obj_found = 1'b0;
        for (int i = 0; i < `VID_OBJ_COUNT; i++) begin
            if (!obj_found && obj_img[i].color != 4'd0 &&
                px >= int'(obj_img[i].x) && px < int'(obj_img[i].x) + 8 &&
                py >= int'(obj_img[i].y) && py < int'(obj_img[i].y) + 8) begin
                obj_found = 1'b1;
                exp_idx   = 5'(16 + int'(obj_img[i].color));
            end
        end
        exp_rgb = pal_img[exp_idx];
    end

    a_hline: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen && armed && hs_rise |-> hcnt == `VID_H_TOTAL)
        else begin
            hline_errs++;
            $display("mismatch HS period: got %h exp %h", $sampled(hcnt), `VID_H_TOTAL);
        end

    a_hact: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen && armed && lhbl_fall |-> hact == `VID_H_ACTIVE)
        else begin
            hact_errs++;
            $display("mismatch LHBL_dly count: got %h exp %h", $sampled(hact), `VID_H_ACTIVE);
        end

    a_vline: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen && armed && vs_rise |-> lcnt == `VID_V_TOTAL)
        else begin
            vline_errs++;
            $display("mismatch VS period: got %h exp %h", $sampled(lcnt), `VID_V_TOTAL);
        end

    a_vact: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen && armed && vs_rise |-> vact == `VID_V_ACTIVE)
        else begin
            vact_errs++;
            $display("mismatch LVBL_dly lines: got %h exp %h", $sampled(vact), `VID_V_ACTIVE);
        end

    a_pixel: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen && armed && LHBL_dly && LVBL_dly |-> rgb == exp_rgb)
        else begin
            pixel_errs++;
            $display("mismatch rgb at (%0d,%0d): got %h exp %h",
                     $sampled(px), $sampled(py), $sampled(rgb), $sampled(exp_rgb));
        end

    a_blank: assert property (@(posedge clk) disable iff (!rst_n)
        (!LHBL_dly || !LVBL_dly) |-> rgb == '0)
        else begin
            blank_errs++;
            $display("mismatch rgb in blanking: got %h exp %h", $sampled(rgb), 12'h000);
        end

    a_rom_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rom_cs && !rom_ok |=> rom_cs)
        else begin
            rom_errs++;
            $display("rom_cs dropped before the ROM answered with rom_ok");
        end

    task automatic cpu_write(input logic [7:0] addr, input logic [7:0] data,
                             input logic to_vram);
        cpu_addr = addr;
        cpu_dout = data;
        vram_cs  = to_vram;
        obj_cs   = !to_vram;
        cpu_we   = 1'b1;
        @(posedge clk);
        #1;
        cpu_we   = 1'b0;
        vram_cs  = 1'b0;
        obj_cs   = 1'b0;
    endtask

    task automatic load_palette();
        for (int i = 0; i < `VID_PAL_DEPTH; i++) begin
            pal_img[5'(i)] = 12'($random(seed));
            prog_addr      = 5'(i);
            prog_data      = pal_img[5'(i)];
            prog_en        = 1'b1;
            @(posedge clk);
            #1;
        end
        prog_en = 1'b0;
    endtask

    task automatic fill_vram();
        logic [7:0] code;
        for (int i = 0; i < `VID_VRAM_DEPTH; i++) begin
            code            = 8'($random(seed));
            vram_img[5'(i)] = code;
            cpu_write(8'(i), code, 1'b1);
        end
    endtask

    task automatic place_object(input logic [1:0] idx, input logic [7:0] x,
                                input logic [7:0] y, input logic [3:0] color);
        obj_img[idx] = '{y: y, x: x, color: color};
        cpu_write({4'd0, idx, 2'd0}, y, 1'b0);
        cpu_write({4'd0, idx, 2'd1}, x, 1'b0);
        cpu_write({4'd0, idx, 2'd2}, {4'd0, color}, 1'b0);
    endtask

    task automatic wait_frame(input string what);
        int start;
        int n;
        start = vs_count;
        n     = 0;
        while (vs_count == start && n < frame_limit) begin
            @(posedge clk);
            n++;
        end
        if (vs_count == start) begin
            timeouts++;
            $display("timeout: no VS pulse while waiting for %s", what);
        end
        #1;
    endtask

    initial begin
        rst_n     = 1'b0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        cpu_we    = 1'b0;
        vram_cs   = 1'b0;
        obj_cs    = 1'b0;
        prog_en   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        load_palette();
        fill_vram();
        place_object(2'd0, 8'd10, 8'd6, 4'd5);
        // Overlaps object 0 and stays behind it
        place_object(2'd1, 8'd14, 8'd9, 4'd9);
        // Transparent, in front of object 3 where they overlap
        place_object(2'd2, 8'd40, 8'd24, 4'd0);
        // Crosses the right and bottom screen edges
        place_object(2'd3, 8'd44, 8'd28, 4'd3);
        wait_frame("the first VS");
        wait_frame("the end of frame 1");
        wait_frame("the end of frame 2");
        // Move during vertical blanking
        place_object(2'd0, 8'd30, 8'd18, 4'd5);
        wait_frame("the end of frame 3");
        repeat (4) @(posedge clk);
        total = hline_errs + hact_errs + vline_errs + vact_errs +
                pixel_errs + blank_errs + rom_errs + timeouts;
        $write("errors: hline %0d hact %0d vline %0d vact %0d",
               hline_errs, hact_errs, vline_errs, vact_errs);
        $display(" pixel %0d blank %0d rom %0d timeout %0d",
                 pixel_errs, blank_errs, rom_errs, timeouts);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
logic/video_timing_pkg.sv
logic/video_gfx_pkg.sv
logic/cpu_ram.sv
logic/video_timer.sv
logic/tile_layer.sv
logic/obj_layer.sv
logic/color_mixer.sv
logic/video_top.sv
dv/video_tb.sv

// ==== Makefile ====
# Verilator flow for the video subsystem
TB = video_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module video_top

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TB) -o $(TB)
	@out=$$(./obj_dir/$(TB)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
